// ==== debug_uart_pkg.sv ====
/* widths, timing constants, vector types, the dump state enum
   and the structs passed between the bridge blocks */
package debug_uart_pkg;

    // status payload, sent most significant byte first
    localparam int STATUS_WIDTH = 16;
    localparam int STATUS_BYTES = STATUS_WIDTH / 8;

    // kept small for simulation, a hardware build raises both
    localparam int UART_TICKS_PER_BIT = 4;
    localparam int DUMP_PERIOD_TICKS = 400;

    localparam int BIT_TICK_WIDTH = $clog2(UART_TICKS_PER_BIT + 1);
    localparam int DUMP_COUNT_WIDTH = $clog2(DUMP_PERIOD_TICKS);
    localparam int BYTE_IDX_WIDTH = $clog2(STATUS_BYTES + 1);

    typedef logic [STATUS_WIDTH-1:0] status_word_t;
    typedef logic [7:0] uart_byte_t;
    typedef logic [BIT_TICK_WIDTH-1:0] bit_tick_t;
    typedef logic [2:0] bit_idx_t;
    typedef logic [BYTE_IDX_WIDTH-1:0] byte_idx_t;
    typedef logic [DUMP_COUNT_WIDTH-1:0] dump_count_t;

    localparam uart_byte_t NEWLINE_BYTE = 8'h0A;
    localparam bit_tick_t BIT_LAST_TICK = bit_tick_t'(UART_TICKS_PER_BIT - 1);
    // first receiver sample after the start edge, lands near mid-bit
    localparam bit_tick_t BIT_HALF_TICK = bit_tick_t'(UART_TICKS_PER_BIT / 2 - 1);
    localparam bit_idx_t BIT_IDX_LAST = 3'd7;
    localparam dump_count_t DUMP_LAST_COUNT = dump_count_t'(DUMP_PERIOD_TICKS - 1);
    localparam byte_idx_t BYTE_IDX_FULL = byte_idx_t'(STATUS_BYTES);

    typedef enum logic [1:0] {
        DUMP_IDLE,
        DUMP_START,
        DUMP_SEND,
        DUMP_WAIT
    } dump_state_t;

    typedef struct packed {
        logic       start;
        uart_byte_t data;
    } tx_req_t;

    typedef struct packed {
        uart_byte_t data;
        logic       valid;
        logic       busy;
    } rx_cmd_t;

endpackage

// ==== dump_timer.sv ====
/* free-running dump request timer */
`timescale 1ns/1ps

module dump_timer
    import debug_uart_pkg::*;
(
    input  logic i_clk_in,
    input  logic i_reset,
    output logic o_dump_req
);

    dump_count_t count;

    // one request per wrap, sets the rate of the debug stream
    always_ff @(posedge i_clk_in) begin
        if (i_reset) begin
            count <= '0;
            o_dump_req <= 1'b0;
        end else if (count == DUMP_LAST_COUNT) begin
            count <= '0;
            o_dump_req <= 1'b1;
        end else begin
            count <= count + 1'b1;
            o_dump_req <= 1'b0;
        end
    end

endmodule

// ==== dump_sequencer.sv ====
/* dump control FSM, latches the status word and feeds its bytes
   and the trailing newline to the UART transmitter */
`timescale 1ns/1ps

module dump_sequencer
    import debug_uart_pkg::*;
(
    input  logic         i_clk_in,
    input  logic         i_reset,
    input  logic         i_dump_req,
    input  logic         i_tx_busy,
    input  status_word_t i_status,
    output tx_req_t      o_tx_req,
    output dump_state_t  o_state
);

    dump_state_t  state;
    status_word_t status_q;
    byte_idx_t    byte_idx;
    logic         do_close;
    logic         tx_start;
    uart_byte_t   tx_data;
    uart_byte_t   next_byte;
    logic         accept;
    logic         issue;

    // requests outside idle are simply dropped
    assign accept = (state == DUMP_IDLE) && i_dump_req;
    assign issue = (state == DUMP_SEND) && !i_tx_busy;

    // index counts down, so the top byte goes out first
    always_comb begin
        next_byte = status_q[8*(byte_idx - 1'b1) +: 8];
    end

    always_ff @(posedge i_clk_in) begin
        if (i_reset) begin
            state <= DUMP_IDLE;
            byte_idx <= '0;
            do_close <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            case (state)
                DUMP_IDLE: begin
                    if (accept) begin
                        byte_idx <= BYTE_IDX_FULL;
                        state <= DUMP_START;
                    end
                end
                DUMP_START: begin
                    // all payload bytes gone, newline comes next
                    if (byte_idx == '0) begin
                        do_close <= 1'b1;
                    end
                    state <= DUMP_SEND;
                end
                DUMP_SEND: begin
                    if (issue) begin
                        tx_start <= 1'b1;
                        state <= DUMP_WAIT;
                    end
                end
                DUMP_WAIT: begin
                    tx_start <= 1'b0;
                    // busy rises one cycle after start, so skip the start cycle
                    if (!i_tx_busy && !tx_start) begin
                        if (do_close) begin
                            do_close <= 1'b0;
                            state <= DUMP_IDLE;
                        end else begin
                            byte_idx <= byte_idx - 1'b1;
                            state <= DUMP_START;
                        end
                    end
                end
                default: begin
                    state <= DUMP_IDLE;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge i_clk_in) begin
        if (accept) begin
            status_q <= i_status;
        end
        if (issue) begin
            tx_data <= do_close ? NEWLINE_BYTE : next_byte;
        end
    end

    assign o_tx_req = '{start: tx_start, data: tx_data};
    assign o_state = state;

endmodule

// ==== uart_tx.sv ====
/* 8N1 UART transmitter, one start bit, eight data bits lsb first,
   one stop bit */
`timescale 1ns/1ps

module uart_tx
    import debug_uart_pkg::*;
(
    input  logic    i_clk_in,
    input  logic    i_reset,
    input  tx_req_t i_tx_req,
    output logic    o_tx_busy,
    output logic    o_tx
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t  state;
    bit_tick_t  tick;
    bit_idx_t   bit_idx;
    uart_byte_t shift_q;

    always_ff @(posedge i_clk_in) begin
        if (i_reset) begin
            state <= TX_IDLE;
            tick <= '0;
            bit_idx <= '0;
            o_tx_busy <= 1'b0;
            o_tx <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (i_tx_req.start) begin
                        o_tx_busy <= 1'b1;
                        o_tx <= 1'b0;
                        tick <= '0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    tick <= tick + 1'b1;
                    if (tick == BIT_LAST_TICK) begin
                        tick <= '0;
                        bit_idx <= '0;
                        o_tx <= shift_q[0];
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    tick <= tick + 1'b1;
                    if (tick == BIT_LAST_TICK) begin
                        tick <= '0;
                        if (bit_idx == BIT_IDX_LAST) begin
                            o_tx <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            o_tx <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    tick <= tick + 1'b1;
                    // full stop bit on the line before busy drops
                    if (tick == BIT_LAST_TICK) begin
                        tick <= '0;
                        o_tx_busy <= 1'b0;
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // shifter loads on start and moves one place per data bit driven
    always_ff @(posedge i_clk_in) begin
        if (state == TX_IDLE && i_tx_req.start) begin
            shift_q <= i_tx_req.data;
        end else if (state != TX_IDLE && state != TX_STOP && tick == BIT_LAST_TICK) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

// ==== uart_rx.sv ====
/* 8N1 UART receiver with input synchronizer, mid-bit sampling
   and stop bit check */
`timescale 1ns/1ps

module uart_rx
    import debug_uart_pkg::*;
(
    input  logic    i_clk_in,
    input  logic    i_reset,
    input  logic    i_rx,
    output rx_cmd_t o_cmd
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    bit_tick_t  tick;
    bit_idx_t   bit_idx;
    uart_byte_t shift_q;
    uart_byte_t cmd_data;
    logic       cmd_valid;
    logic       rx_busy;
    logic       sample;

    // two flops against metastability, a third for edge detection
    always_ff @(posedge i_clk_in) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // mid-bit point for data and stop bits
    assign sample = (tick == BIT_LAST_TICK);

    always_ff @(posedge i_clk_in) begin
        if (i_reset) begin
            state <= RX_IDLE;
            tick <= '0;
            bit_idx <= '0;
            cmd_valid <= 1'b0;
            rx_busy <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            tick <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (rx_prev && !rx_sync) begin
                        rx_busy <= 1'b1;
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // line back high at mid-bit means a glitch, not a frame
                    if (tick == BIT_HALF_TICK) begin
                        tick <= '0;
                        bit_idx <= '0;
                        if (rx_sync) begin
                            rx_busy <= 1'b0;
                            state <= RX_IDLE;
                        end else begin
                            state <= RX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        tick <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == BIT_IDX_LAST) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        tick <= '0;
                        cmd_valid <= rx_sync;
                        rx_busy <= 1'b0;
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // payload, held until the next good frame
    always_ff @(posedge i_clk_in) begin
        if (state == RX_DATA && sample) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
        if (state == RX_STOP && sample && rx_sync) begin
            cmd_data <= shift_q;
        end
    end

    assign o_cmd = '{data: cmd_data, valid: cmd_valid, busy: rx_busy};

endmodule

// ==== debug_uart_top.sv ====
/* debug serial bridge top, periodic status dump out on tx and
   command bytes in from rx */
`timescale 1ns/1ps

module debug_uart_top
    import debug_uart_pkg::*;
(
    input  logic         i_clk_in,
    input  logic         i_reset,
    input  logic         i_rx,
    input  status_word_t i_status,
    output logic         o_tx,
    output rx_cmd_t      o_cmd,
    output dump_state_t  o_dump_state
);

    logic    dump_req;
    logic    tx_busy;
    tx_req_t tx_req;

    dump_timer dump_timer_i (
        .i_clk_in  (i_clk_in),
        .i_reset   (i_reset),
        .o_dump_req(dump_req)
    );

    // transmitter busy is the only back-pressure on the dump
    dump_sequencer dump_sequencer_i (
        .i_clk_in  (i_clk_in),
        .i_reset   (i_reset),
        .i_dump_req(dump_req),
        .i_tx_busy (tx_busy),
        .i_status  (i_status),
        .o_tx_req  (tx_req),
        .o_state   (o_dump_state)
    );

    uart_tx uart_tx_i (
        .i_clk_in (i_clk_in),
        .i_reset  (i_reset),
        .i_tx_req (tx_req),
        .o_tx_busy(tx_busy),
        .o_tx     (o_tx)
    );

    // command path runs independently of the dump
    uart_rx uart_rx_i (
        .i_clk_in(i_clk_in),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_cmd   (o_cmd)
    );

endmodule

// ==== debug_uart_top_tb.sv ====
/* testbench for the debug serial bridge, dump frame decoder, command frame driver,
   LFSR stimulus, stimulus table and timeout */
`timescale 1ns/1ps

module debug_uart_top_tb
    import debug_uart_pkg::*;
();

    localparam int NUM_ROWS = 8;
    localparam int NUM_FIXED = 4;
    localparam int TIMEOUT_CYCLES = (NUM_ROWS + 2) * DUMP_PERIOD_TICKS;

    logic         clk_in = 1'b0;
    logic         i_reset;
    logic         i_rx;
    status_word_t i_status;
    logic         o_tx;
    rx_cmd_t      o_cmd;
    dump_state_t  o_dump_state;

    // stimulus table, one entry per dump period
    string        row_name [NUM_ROWS];
    status_word_t row_word [NUM_ROWS];
    uart_byte_t   row_cmd [NUM_ROWS];
    logic         row_good_stop [NUM_ROWS];

    logic [15:0] lfsr_state = 16'h0001;
    int          cycle_count = 0;
    int          release_cycle = 0;
    logic        monitor_on = 1'b0;

    debug_uart_top debug_uart_top_i (
        .i_clk_in    (clk_in),
        .i_reset     (i_reset),
        .i_rx        (i_rx),
        .i_status    (i_status),
        .o_tx        (o_tx),
        .o_cmd       (o_cmd),
        .o_dump_state(o_dump_state)
    );

    always #2 clk_in = ~clk_in;

    // 16 bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    task automatic take_random_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [15:0] expected, input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input string test_name, input logic condition, input string msg);
        assert (condition === 1'b1) else begin
            $display("error in %s: %s", test_name, msg);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic load_table();
        logic [15:0] rand_value;
        row_name[0] = "fixed_a5c3";
        row_word[0] = 16'hA5C3;
        row_cmd[0] = 8'h3C;
        row_good_stop[0] = 1'b1;
        row_name[1] = "fixed_zero_word";
        row_word[1] = 16'h0000;
        row_cmd[1] = 8'hFF;
        row_good_stop[1] = 1'b1;
        // low stop bit, the receiver must drop this frame
        row_name[2] = "bad_stop_bit";
        row_word[2] = 16'hFFFF;
        row_cmd[2] = 8'h55;
        row_good_stop[2] = 1'b0;
        row_name[3] = "fixed_newline_word";
        row_word[3] = 16'h0A0A;
        row_cmd[3] = 8'h00;
        row_good_stop[3] = 1'b1;
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            take_random_bits(STATUS_WIDTH, rand_value);
            row_word[r] = rand_value;
            take_random_bits(8, rand_value);
            row_cmd[r] = rand_value[7:0];
            row_good_stop[r] = 1'b1;
            row_name[r] = $sformatf("lfsr_row_%0d", r - NUM_FIXED);
        end
    endtask

    task automatic wait_start_bit();
        do begin
            @(negedge clk_in);
        end while (o_tx !== 1'b0);
    endtask

    // called on the first low sample, so about half a cycle into the start bit
    task automatic read_frame(input string test_name, output uart_byte_t value);
        value = '0;
        repeat (UART_TICKS_PER_BIT / 2 - 1) @(negedge clk_in);
        check_true(test_name, o_tx === 1'b0, "start bit on tx did not stay low to mid-bit");
        for (int i = 0; i < 8; i++) begin
            repeat (UART_TICKS_PER_BIT) @(negedge clk_in);
            value[i] = o_tx;
        end
        repeat (UART_TICKS_PER_BIT) @(negedge clk_in);
        check_true(test_name, o_tx === 1'b1, "stop bit on tx was not high");
    endtask

    task automatic drive_rx_frame(input string test_name, input uart_byte_t value,
                                  input logic good_stop);
        i_rx = 1'b0;
        repeat (UART_TICKS_PER_BIT) @(negedge clk_in);
        for (int i = 0; i < 8; i++) begin
            i_rx = value[i];
            check_true(test_name, o_cmd.busy === 1'b1, "receiver not busy during a frame");
            repeat (UART_TICKS_PER_BIT) @(negedge clk_in);
        end
        i_rx = good_stop;
        repeat (UART_TICKS_PER_BIT) @(negedge clk_in);
        i_rx = 1'b1;
    endtask

    task automatic watch_rx_cmd(input string test_name, input uart_byte_t expected,
                                input logic good_stop);
        int         valid_count;
        uart_byte_t captured;
        valid_count = 0;
        captured = '0;
        repeat (2 * UART_TICKS_PER_BIT) begin
            @(negedge clk_in);
            if (o_cmd.valid === 1'b1) begin
                valid_count++;
                captured = o_cmd.data;
            end
        end
        check_value(test_name, "valid pulse count", good_stop ? 16'd1 : 16'd0, valid_count);
        if (good_stop) begin
            check_value(test_name, "command byte", expected, captured);
        end
        check_true(test_name, o_cmd.busy === 1'b0, "receiver still busy after the frame");
    endtask

    task automatic run_row(input int row);
        uart_byte_t got_byte;
        int         idle_wait;
        i_status = row_word[row];
        fork
            begin
                wait_start_bit();
                if (row == 0) begin
                    check_true(row_name[row], cycle_count - release_cycle >= DUMP_PERIOD_TICKS,
                               "start bit on tx came before one dump period after reset");
                end
                // word must already be latched, so disturb the input now
                i_status = ~row_word[row];
                read_frame(row_name[row], got_byte);
                check_value(row_name[row], "high byte", row_word[row][15:8], got_byte);
                wait_start_bit();
                read_frame(row_name[row], got_byte);
                check_value(row_name[row], "low byte", row_word[row][7:0], got_byte);
                wait_start_bit();
                read_frame(row_name[row], got_byte);
                check_value(row_name[row], "newline byte", NEWLINE_BYTE, got_byte);
                idle_wait = 0;
                while (o_dump_state != DUMP_IDLE && idle_wait < 4 * UART_TICKS_PER_BIT) begin
                    @(negedge clk_in);
                    idle_wait++;
                end
                check_true(row_name[row], o_dump_state == DUMP_IDLE,
                           "sequencer did not return to idle after the newline");
            end
            begin
                drive_rx_frame(row_name[row], row_cmd[row], row_good_stop[row]);
                watch_rx_cmd(row_name[row], row_cmd[row], row_good_stop[row]);
            end
        join
    endtask

    // frames may only appear while a dump is in progress
    always @(negedge clk_in) begin
        if (monitor_on) begin
            check_true("idle_monitor", !(o_dump_state == DUMP_IDLE && o_tx !== 1'b1),
                       "tx line left idle while the sequencer was idle");
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout, the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    initial begin
        i_reset = 1'b1;
        i_rx = 1'b1;
        i_status = '0;
        load_table();
        repeat (2) @(negedge clk_in);
        i_reset = 1'b0;
        release_cycle = cycle_count;
        @(negedge clk_in);
        check_true("after_reset", o_tx === 1'b1, "tx line not high after reset");
        check_true("after_reset", o_dump_state == DUMP_IDLE, "sequencer not idle after reset");
        check_true("after_reset", o_cmd.valid === 1'b0, "command valid high after reset");
        check_true("after_reset", o_cmd.busy === 1'b0, "receiver busy after reset");
        monitor_on = 1'b1;
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== debug_uart_top.f ====
debug_uart_pkg.sv
dump_timer.sv
dump_sequencer.sv
uart_tx.sv
uart_rx.sv
debug_uart_top.sv
debug_uart_top_tb.sv

// ==== Bender.yml ====
package:
  name: debug_uart

sources:
  - debug_uart_pkg.sv
  - dump_timer.sv
  - dump_sequencer.sv
  - uart_tx.sv
  - uart_rx.sv
  - debug_uart_top.sv
  - target: test
    files:
      - debug_uart_top_tb.sv
